// ==== frontend_top.f ====
verilog/rv_isa_pkg.sv
verilog/pipe_ctrl_pkg.sv
verilog/fetch_stage.sv
verilog/if_id_reg.sv
verilog/decode_stage.sv
verilog/pipe_ctrl.sv
verilog/frontend_top.sv
verification/frontend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f frontend_top.f --top-module frontend_tb -o frontend_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

output=$(./obj_dir/frontend_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qF "All tests passed!"; then
  exit 0
else
  exit 1
fi

// ==== verification/frontend_input.txt ====
# M addr word | S step stall_cycles | R step target (steps count unstalled cycles after reset)
# E pc opcode rd rs1 rs2 imm pred_taken trap (hex, steps in decimal)
M 80000000 00500093
M 80000004 ffd08113
M 80000008 002081b3
M 8000000c ff812203
M 80000010 0041a623
M 80000014 800012b7
M 80000018 00001317
M 8000001c 014000ef
M 80000020 00100393
M 80000024 0140006f
M 80000030 fff40413
M 80000034 fe0418e3
M 80000038 00008067
M 8000003c 0000007f
M 80000040 0060006f
M 80000046 0000006f
M 80000060 fe912e23
M 80000064 0000006f
S 4 3
S 11 2
S 13 1
R 20 80000060
E 80000000 13 01 00 05 00000005 0 0
E 80000004 13 02 01 1d fffffffd 0 0
E 80000008 33 03 01 02 00000000 0 0
E 8000000c 03 04 02 18 fffffff8 0 0
E 80000010 23 0c 03 04 0000000c 0 0
E 80000014 37 05 00 00 80001000 0 0
E 80000018 17 06 00 00 00001000 0 0
E 8000001c 6f 01 00 14 00000014 1 0
E 80000030 13 08 08 1f ffffffff 0 0
E 80000034 63 11 08 00 fffffff0 1 0
E 80000024 6f 00 00 14 00000014 1 0
E 80000038 67 00 01 00 00000000 0 0
E 8000003c 7f 00 00 00 00000000 0 2
E 80000040 6f 00 00 06 00000006 1 0
E 80000046 6f 00 00 00 00000000 0 1
E 80000060 23 1c 02 09 fffffffc 0 0
E 80000064 6f 00 00 00 00000000 1 0
E 80000064 6f 00 00 00 00000000 1 0

// ==== verification/frontend_tb.sv ====
`timescale 1ns/10ps

module frontend_tb;

  localparam int TIMEOUT_CYCLES = 50;

  logic                     clk;
  logic                     arst_n;
  logic                     stall;
  pipe_ctrl_pkg::redirect_t ex_redirect;
  rv_isa_pkg::inst_t        inst_data;
  rv_isa_pkg::addr_t        inst_addr;
  rv_isa_pkg::decoded_t     id_inst;

  rv_isa_pkg::inst_t    mem [rv_isa_pkg::addr_t];
  int                   stall_at [int];  // Step number to stall length
  rv_isa_pkg::addr_t    redirect_at [int];
  rv_isa_pkg::decoded_t expected [$];
  bit                   done;
  bit                   advanced;  // Last edge loaded new values

  frontend_top frontend_top_inst (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .stall_i       (stall),
    .ex_redirect_i (ex_redirect),
    .inst_data_i   (inst_data),
    .inst_addr_o   (inst_addr),
    .id_inst_o     (id_inst)
  );

  always #50 clk = ~clk;

  function automatic rv_isa_pkg::inst_t word_at(input rv_isa_pkg::addr_t addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return rv_isa_pkg::INST_NOP;
  endfunction

  always_comb begin
    inst_data = word_at(inst_addr);  // Zero latency memory
  end

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_addr(input string name, input rv_isa_pkg::addr_t got,
                            input rv_isa_pkg::addr_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_decoded(input rv_isa_pkg::decoded_t got,
                               input rv_isa_pkg::decoded_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: id_inst_o got %h expected %h", $time, got, exp);
      $display("  got      pc %h op %h rd %0d rs1 %0d rs2 %0d imm %h pred %b trap %0d",
               got.pc, got.opcode, got.rd, got.rs1, got.rs2, got.imm,
               got.pred_taken, got.trap);
      $display("  expected pc %h op %h rd %0d rs1 %0d rs2 %0d imm %h pred %b trap %0d",
               exp.pc, exp.opcode, exp.rd, exp.rs1, exp.rs2, exp.imm,
               exp.pred_taken, exp.trap);
      abort_run();
    end
  endtask

  task automatic parse_line(input string line);
    logic [31:0]          pc;
    logic [31:0]          op;
    logic [31:0]          rd;
    logic [31:0]          rs1;
    logic [31:0]          rs2;
    logic [31:0]          imm;
    logic [31:0]          pred;
    logic [31:0]          trap;
    int                   step;
    int                   len;
    int                   n;
    rv_isa_pkg::inst_t    word;
    rv_isa_pkg::decoded_t entry;
    n = 0;
    case (line[0])
      "M": begin
        n = $sscanf(line, "M %h %h", pc, op);
        mem[pc] = op;
      end
      "S": begin
        n = $sscanf(line, "S %d %d", step, len);
        stall_at[step] = len;
      end
      "R": begin
        n = $sscanf(line, "R %d %h", step, pc);
        redirect_at[step] = pc;
      end
      "E": begin
        n = $sscanf(line, "E %h %h %h %h %h %h %h %h",
                    pc, op, rd, rs1, rs2, imm, pred, trap);
        word = word_at(pc);
        entry.valid      = 1'b1;
        entry.pc         = pc;
        entry.opcode     = rv_isa_pkg::opcode_e'(op[6:0]);
        entry.funct3     = word[14:12];  // Raw fields of the stored word
        entry.funct7     = word[31:25];
        entry.rd         = rd[4:0];
        entry.rs1        = rs1[4:0];
        entry.rs2        = rs2[4:0];
        entry.imm        = imm;
        entry.pred_taken = pred[0];
        entry.trap       = rv_isa_pkg::trap_e'(trap[1:0]);
        expected.push_back(entry);
      end
      default: begin
        $display("Unknown line in stimulus file: %s", line);
        abort_run();
      end
    endcase
    if (n < 2) begin
      $display("Stimulus line could not be parsed: %s", line);
      abort_run();
    end
  endtask

  task automatic load_stimulus();
    int    fd;
    string line;
    fd = $fopen("verification/frontend_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file verification/frontend_input.txt");
      abort_run();
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() > 1 && line[0] != "#") begin
        parse_line(line);
      end
    end
    $fclose(fd);
    if (expected.size() == 0) begin
      $display("Stimulus file holds no expected decoded entries");
      abort_run();
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    arst_n      <= 1'b0;
    stall       <= 1'b0;
    ex_redirect <= '0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
  endtask

  // Each step is one unstalled cycle with its stalls in front
  task automatic drive_steps(input bit random_stalls);
    int                       step;
    int                       stall_cycles;
    pipe_ctrl_pkg::redirect_t redirect;
    step = 0;
    while (!done) begin
      stall_cycles = stall_at.exists(step) ? stall_at[step] : 0;
      if (random_stalls && ($urandom % 4) == 0) begin
        stall_cycles = stall_cycles + 1 + int'($urandom % 3);
      end
      repeat (stall_cycles) begin
        stall       <= 1'b1;
        ex_redirect <= '0;
        @(posedge clk);
      end
      redirect = '0;
      if (redirect_at.exists(step)) begin
        redirect.valid  = 1'b1;
        redirect.target = redirect_at[step];
      end
      stall       <= 1'b0;
      ex_redirect <= redirect;
      @(posedge clk);
      step++;
    end
    stall       <= 1'b0;
    ex_redirect <= '0;
  endtask

  task automatic wait_entry(output rv_isa_pkg::decoded_t got);
    int cycles;
    bit found;
    cycles = 0;
    found  = 1'b0;
    while (!found) begin
      @(negedge clk);
      found    = advanced && id_inst.valid;
      advanced = !stall || ex_redirect.valid;
      cycles++;
      if (!found && cycles >= TIMEOUT_CYCLES) begin
        $display("No decoded instruction arrived within %0d cycles at %0t",
                 TIMEOUT_CYCLES, $time);
        abort_run();
      end
    end
    got = id_inst;
  endtask

  task automatic check_stream();
    rv_isa_pkg::decoded_t got;
    @(negedge clk);
    check_addr("inst_addr_o", inst_addr, rv_isa_pkg::PC_RESET_ADDR);
    if (id_inst.valid) begin
      $display("Decoded output is valid right after reset at %0t", $time);
      abort_run();
    end
    advanced = !stall || ex_redirect.valid;
    foreach (expected[i]) begin
      wait_entry(got);
      check_decoded(got, expected[i]);
    end
    done = 1'b1;
  endtask

  initial begin
    clk         = 1'b0;
    arst_n      = 1'b1;
    stall       = 1'b0;
    ex_redirect = '0;
    done        = 1'b0;
    advanced    = 1'b0;
    void'($urandom(32'h82fef91c));
    load_stimulus();
    // Second pass repeats the program with random back-end stalls
    for (int pass = 0; pass < 2; pass++) begin
      done = 1'b0;
      apply_reset();
      fork
        drive_steps(pass == 1);
        check_stream();
      join
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      stall_i,
  input  logic                      flush_i,
  input  pipe_ctrl_pkg::if_slot_t   slot_i,
  output pipe_ctrl_pkg::redirect_t  redirect_o,
  output rv_isa_pkg::decoded_t      id_inst_o
);

  rv_isa_pkg::inst_t    inst;
  rv_isa_pkg::opcode_e  opcode;
  logic [31:0]          imm_i;
  logic [31:0]          imm_s;
  logic [31:0]          imm_b;
  logic [31:0]          imm_u;
  logic [31:0]          imm_j;
  logic [31:0]          imm;
  logic                 legal;
  logic                 predict;
  logic                 taken;
  rv_isa_pkg::trap_e    trap;
  rv_isa_pkg::decoded_t dec_d;
  rv_isa_pkg::decoded_t dec_q;

  assign inst   = slot_i.inst;
  assign opcode = rv_isa_pkg::opcode_e'(inst[6:0]);

  // Immediate formats
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    legal   = 1'b1;
    predict = 1'b0;
    imm     = 32'd0;
    case (opcode)
      rv_isa_pkg::OP_LUI,
      rv_isa_pkg::OP_AUIPC:  imm = imm_u;
      rv_isa_pkg::OP_JAL: begin
        imm     = imm_j;
        predict = 1'b1;  // Always taken
      end
      rv_isa_pkg::OP_BRANCH: begin
        imm     = imm_b;
        predict = imm_b[31];  // Backward taken
      end
      rv_isa_pkg::OP_JALR,
      rv_isa_pkg::OP_LOAD,
      rv_isa_pkg::OP_IMM,
      rv_isa_pkg::OP_SYSTEM: imm = imm_i;
      rv_isa_pkg::OP_STORE:  imm = imm_s;
      rv_isa_pkg::OP_REG:    imm = 32'd0;
      default:               legal = 1'b0;
    endcase
  end

  // Earlier trap from fetch is kept
  always_comb begin
    if (slot_i.trap != rv_isa_pkg::TRAP_NONE) begin
      trap = slot_i.trap;
    end else if (!legal) begin
      trap = rv_isa_pkg::TRAP_ILLEGAL;
    end else begin
      trap = rv_isa_pkg::TRAP_NONE;
    end
  end

  assign taken = slot_i.valid && (trap == rv_isa_pkg::TRAP_NONE) && predict;

  assign redirect_o.valid  = taken;
  assign redirect_o.target = slot_i.pc + imm;

  always_comb begin
    dec_d.valid      = slot_i.valid;
    dec_d.pc         = slot_i.pc;
    dec_d.opcode     = opcode;
    dec_d.funct3     = inst[14:12];
    dec_d.funct7     = inst[31:25];
    dec_d.rd         = inst[11:7];
    dec_d.rs1        = inst[19:15];
    dec_d.rs2        = inst[24:20];
    dec_d.imm        = imm;
    dec_d.pred_taken = taken;
    dec_d.trap       = trap;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dec_q <= rv_isa_pkg::DEC_BUBBLE;
    end else if (flush_i) begin
      dec_q <= rv_isa_pkg::DEC_BUBBLE;
    end else if (!stall_i) begin
      dec_q <= dec_d;
    end
  end

  assign id_inst_o = dec_q;

endmodule

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   stall_i,
  input  pipe_ctrl_pkg::redirect_t redirect_i,
  input  rv_isa_pkg::inst_t      inst_data_i,
  output rv_isa_pkg::addr_t      inst_addr_o,
  output pipe_ctrl_pkg::if_slot_t slot_o
);

  rv_isa_pkg::addr_t pc_q;
  rv_isa_pkg::addr_t pc_d;
  logic              misaligned;

  always_comb begin
    if (redirect_i.valid) begin
      pc_d = redirect_i.target;  // Redirect beats stall
    end else if (stall_i) begin
      pc_d = pc_q;
    end else begin
      pc_d = pc_q + rv_isa_pkg::addr_t'(rv_isa_pkg::INST_BYTES);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= rv_isa_pkg::PC_RESET_ADDR;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign misaligned = (pc_q[1:0] != 2'b00);

  // Memory answers in the same cycle
  assign inst_addr_o = pc_q;

  always_comb begin
    slot_o.valid      = 1'b1;
    slot_o.pc         = pc_q;
    slot_o.inst       = inst_data_i;
    slot_o.pred_taken = 1'b0;  // Prediction happens in decode
    slot_o.trap       = misaligned ? rv_isa_pkg::TRAP_MISALIGNED : rv_isa_pkg::TRAP_NONE;
  end

endmodule

// ==== verilog/frontend_top.sv ====
`timescale 1ns/10ps

module frontend_top (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     stall_i,
  input  pipe_ctrl_pkg::redirect_t ex_redirect_i,
  input  rv_isa_pkg::inst_t        inst_data_i,
  output rv_isa_pkg::addr_t        inst_addr_o,
  output rv_isa_pkg::decoded_t     id_inst_o
);

  pipe_ctrl_pkg::if_slot_t   fetch_slot;
  pipe_ctrl_pkg::if_slot_t   if_id_slot;
  pipe_ctrl_pkg::redirect_t  id_redirect;
  pipe_ctrl_pkg::redirect_t  redirect;
  pipe_ctrl_pkg::stage_ctl_t stall;
  pipe_ctrl_pkg::stage_ctl_t flush;

  fetch_stage fetch_stage_inst (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .stall_i     (stall.fetch),
    .redirect_i  (redirect),
    .inst_data_i (inst_data_i),
    .inst_addr_o (inst_addr_o),
    .slot_o      (fetch_slot)
  );

  if_id_reg if_id_reg_inst (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .stall_i  (stall.if_id),
    .flush_i  (flush.if_id),
    .slot_i   (fetch_slot),
    .slot_o   (if_id_slot)
  );

  decode_stage decode_stage_inst (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .stall_i    (stall.id_out),
    .flush_i    (flush.id_out),
    .slot_i     (if_id_slot),
    .redirect_o (id_redirect),
    .id_inst_o  (id_inst_o)
  );

  pipe_ctrl pipe_ctrl_inst (
    .stall_i       (stall_i),
    .ex_redirect_i (ex_redirect_i),
    .id_redirect_i (id_redirect),
    .stall_o       (stall),
    .flush_o       (flush),
    .redirect_o    (redirect)
  );

endmodule

// ==== verilog/if_id_reg.sv ====
`timescale 1ns/10ps

module if_id_reg (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    stall_i,
  input  logic                    flush_i,
  input  pipe_ctrl_pkg::if_slot_t slot_i,
  output pipe_ctrl_pkg::if_slot_t slot_o
);

  pipe_ctrl_pkg::if_slot_t slot_q;

  // Flush wins so an execute redirect clears a stalled slot
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      slot_q <= pipe_ctrl_pkg::SLOT_BUBBLE;
    end else if (flush_i) begin
      slot_q <= pipe_ctrl_pkg::SLOT_BUBBLE;  // NOP bubble
    end else if (!stall_i) begin
      slot_q <= slot_i;
    end
  end

  assign slot_o = slot_q;

endmodule

// ==== verilog/pipe_ctrl.sv ====
`timescale 1ns/10ps

module pipe_ctrl (
  input  logic                      stall_i,
  input  pipe_ctrl_pkg::redirect_t  ex_redirect_i,
  input  pipe_ctrl_pkg::redirect_t  id_redirect_i,
  output pipe_ctrl_pkg::stage_ctl_t stall_o,
  output pipe_ctrl_pkg::stage_ctl_t flush_o,
  output pipe_ctrl_pkg::redirect_t  redirect_o
);

  always_comb begin
    stall_o    = '0;
    flush_o    = '0;
    redirect_o = '0;

    if (ex_redirect_i.valid) begin
      // Mispredict or trap from execute empties the front end
      flush_o.fetch  = 1'b1;
      flush_o.if_id  = 1'b1;
      flush_o.id_out = 1'b1;
      redirect_o     = ex_redirect_i;
    end else if (stall_i) begin
      stall_o.fetch  = 1'b1;
      stall_o.if_id  = 1'b1;
      stall_o.id_out = 1'b1;  // Decode redirect comes back after the stall
    end else if (id_redirect_i.valid) begin
      flush_o.if_id = 1'b1;  // Drop the fall-through
      redirect_o    = id_redirect_i;
    end
  end

endmodule

// ==== verilog/pipe_ctrl_pkg.sv ====
package pipe_ctrl_pkg;

  // One bit per stage for both stall and flush
  typedef struct packed {
    logic fetch;
    logic if_id;
    logic id_out;
  } stage_ctl_t;

  typedef struct packed {
    logic                valid;
    rv_isa_pkg::addr_t   target;
  } redirect_t;

  typedef struct packed {
    logic                valid;
    rv_isa_pkg::addr_t   pc;
    rv_isa_pkg::inst_t   inst;
    logic                pred_taken;
    rv_isa_pkg::trap_e   trap;
  } if_slot_t;

  localparam if_slot_t SLOT_BUBBLE = '{
    valid: 1'b0,
    pc: '0,
    inst: rv_isa_pkg::INST_NOP,
    pred_taken: 1'b0,
    trap: rv_isa_pkg::TRAP_NONE
  };

endpackage

// ==== verilog/rv_isa_pkg.sv ====
package rv_isa_pkg;

  localparam int XLEN = 32;
  localparam int INST_BYTES = 4;  // No compressed instructions

  typedef logic [XLEN-1:0] addr_t;
  typedef logic [31:0] inst_t;

  localparam addr_t PC_RESET_ADDR = 32'h8000_0000;
  localparam inst_t INST_NOP = 32'h0000_0013;  // addi x0, x0, 0

  // Only these RV32I major opcodes are legal
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [1:0] {
    TRAP_NONE       = 2'd0,
    TRAP_MISALIGNED = 2'd1,
    TRAP_ILLEGAL    = 2'd2
  } trap_e;

  typedef struct packed {
    logic        valid;
    addr_t       pc;
    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;         // Sign extended per format
    logic        pred_taken;
    trap_e       trap;
  } decoded_t;

  // Decoded form of INST_NOP with valid low
  localparam decoded_t DEC_BUBBLE = '{
    valid: 1'b0,
    pc: '0,
    opcode: OP_IMM,
    funct3: 3'b000,
    funct7: 7'b0000000,
    rd: 5'd0,
    rs1: 5'd0,
    rs2: 5'd0,
    imm: 32'd0,
    pred_taken: 1'b0,
    trap: TRAP_NONE
  };

endpackage
